/* source/neuralPkg.sv */
package neuralPkg;

	// Fixed-point widths used across the layer
	typedef logic signed [7:0] activationT;
	typedef logic signed [7:0] weightT;
	typedef logic signed [15:0] productT;

	// Fifteen full-scale products plus the bias still fit in 23 bits
	typedef logic signed [22:0] accumT;

	// Inputs per neuron
	parameter int FEATURES = 15;

	// Register stages from features to activation inside one node
	parameter int NODE_LATENCY = 3;

	// The rectifier clips here
	parameter int ACT_MAX = 127;

	// Feature 0 sits in value[0]
	typedef struct packed
	{
		activationT [FEATURES-1:0] value;
	} featureVectorT;

	// Weight i multiplies feature i, and the bias is added once
	typedef struct packed
	{
		weightT bias;
		weightT [FEATURES-1:0] weight;
	} nodeWeightsT;

endpackage

/* source/featureLoader.sv */
`timescale 1ns/10ps

module featureLoader #(
	parameter int NEURONS = 4,
	parameter int FEATURES = neuralPkg::FEATURES
)
(
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input neuralPkg::activationT sampleData,
	input logic weightWrite,
	input logic [$clog2(NEURONS)-1:0] weightNeuron,
	input logic [$clog2(FEATURES+1)-1:0] weightIndex,
	input neuralPkg::weightT weightData,
	output neuralPkg::featureVectorT features,
	output logic vectorValid,
	output neuralPkg::nodeWeightsT [NEURONS-1:0] nodeWeights
);

	localparam int COUNT_W = $clog2(FEATURES);

	logic [COUNT_W-1:0] sampleCount;
	logic lastSample;
	neuralPkg::featureVectorT staging;
	neuralPkg::featureVectorT completed;

	assign lastSample = sampleValid && (sampleCount == COUNT_W'(FEATURES - 1));

	// Staging vector with the current strobe already placed at its slot
	always_comb
	begin
		completed = staging;
		completed.value[sampleCount] = sampleData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sampleCount <= '0;
			vectorValid <= 1'b0;
		end
		else
		begin
			vectorValid <= lastSample; // One cycle, together with the new vector
			if (lastSample)
				sampleCount <= '0;
			else if (sampleValid)
				sampleCount <= sampleCount + 1'b1;
		end
	end

	// The nodes only ever see a complete vector
	always_ff @(posedge clk)
	begin
		if (sampleValid)
			staging <= completed;
		if (lastSample)
			features <= completed;
	end

	// Weight and bias registers, one set per neuron
	always_ff @(posedge clk)
	begin
		if (reset)
			nodeWeights <= '0;
		else if (weightWrite && (weightNeuron < NEURONS))
		begin
			if (weightIndex == FEATURES)
				nodeWeights[weightNeuron].bias <= weightData;
			else if (weightIndex < FEATURES)
				nodeWeights[weightNeuron].weight[weightIndex] <= weightData;
		end
	end

endmodule

/* source/neuronNode.sv */
`timescale 1ns/10ps

module neuronNode #(
	parameter int FEATURES = neuralPkg::FEATURES
)
(
	input logic clk,
	input logic reset,
	input neuralPkg::featureVectorT features,
	input neuralPkg::nodeWeightsT weights,
	output neuralPkg::activationT activation
);

	neuralPkg::featureVectorT featuresReg;
	neuralPkg::productT [FEATURES-1:0] products;
	neuralPkg::accumT sum;
	neuralPkg::accumT sumReg;
	logic [16:0] rounded;

	// Signed products, both operands sign-extended to the product width
	always_comb
	begin
		for (int i = 0; i < FEATURES; i++)
			products[i] = neuralPkg::productT'(featuresReg.value[i])
				* neuralPkg::productT'(weights.weight[i]);
	end

	always_comb
	begin
		sum = neuralPkg::accumT'(weights.bias);
		for (int i = 0; i < FEATURES; i++)
			sum = sum + neuralPkg::accumT'(products[i]);
	end

	// Divide by 64 and round half-up, only looked at for a positive sum
	assign rounded = 17'(sumReg[22:6]) + 17'(sumReg[5]);

	always_ff @(posedge clk)
	begin
		featuresReg <= features;
		sumReg <= sum;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			activation <= '0;
		else if (sumReg[22])
			activation <= '0; // Rectifier
		else if (rounded > 17'(neuralPkg::ACT_MAX))
			activation <= neuralPkg::activationT'(neuralPkg::ACT_MAX);
		else
			activation <= neuralPkg::activationT'(rounded[7:0]);
	end

endmodule

/* source/layerCollector.sv */
`timescale 1ns/10ps

module layerCollector #(
	parameter int NEURONS = 4
)
(
	input logic clk,
	input logic reset,
	input logic vectorValid,
	input neuralPkg::activationT [NEURONS-1:0] nodeOutputs,
	output logic outValid,
	output logic [$clog2(NEURONS)-1:0] outIndex,
	output neuralPkg::activationT outData,
	output logic classValid,
	output logic [$clog2(NEURONS)-1:0] classIndex,
	output neuralPkg::activationT classScore
);

	localparam int INDEX_W = $clog2(NEURONS);

	typedef enum logic {stateIdle, stateStreaming} stateT;

	stateT state;
	logic [neuralPkg::NODE_LATENCY-1:0] validPipe;
	logic startStream;
	logic lastOut;
	logic [INDEX_W-1:0] nextIndex;
	neuralPkg::activationT [NEURONS-1:0] latched;
	logic [INDEX_W-1:0] bestIndex;
	neuralPkg::activationT bestScore;

	// Node outputs are settled once vectorValid has passed the node depth
	assign startStream = validPipe[neuralPkg::NODE_LATENCY-1];
	assign lastOut = (state == stateStreaming) && (outIndex == INDEX_W'(NEURONS - 1));
	assign nextIndex = outIndex + 1'b1;

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[neuralPkg::NODE_LATENCY-2:0], vectorValid};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			outValid <= 1'b0;
			outIndex <= '0;
			outData <= '0;
			classValid <= 1'b0;
		end
		else
		begin
			classValid <= lastOut; // Right after the final activation
			if (startStream)
			begin
				state <= stateStreaming;
				outValid <= 1'b1;
				outIndex <= '0;
				outData <= nodeOutputs[0];
			end
			else
			begin
				case (state)
					stateIdle:
						outValid <= 1'b0;
					stateStreaming:
						if (lastOut)
						begin
							state <= stateIdle;
							outValid <= 1'b0;
						end
						else
						begin
							outIndex <= nextIndex;
							outData <= latched[nextIndex];
						end
					default:
						state <= stateIdle;
				endcase
			end
		end
	end

	// Running maximum, strictly larger wins so ties keep the lower index
	always_ff @(posedge clk)
	begin
		if (startStream)
		begin
			latched <= nodeOutputs;
			bestIndex <= '0;
			bestScore <= nodeOutputs[0];
		end
		else if ((state == stateStreaming) && !lastOut && (latched[nextIndex] > bestScore))
		begin
			bestIndex <= nextIndex;
			bestScore <= latched[nextIndex];
		end
		if (lastOut)
		begin
			classIndex <= bestIndex;
			classScore <= bestScore;
		end
	end

endmodule

/* source/neuralLayer.sv */
`timescale 1ns/10ps

module neuralLayer #(
	parameter int NEURONS = 4,
	parameter int FEATURES = neuralPkg::FEATURES
)
(
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input neuralPkg::activationT sampleData,
	input logic weightWrite,
	input logic [$clog2(NEURONS)-1:0] weightNeuron,
	input logic [$clog2(FEATURES+1)-1:0] weightIndex,
	input neuralPkg::weightT weightData,
	output logic outValid,
	output logic [$clog2(NEURONS)-1:0] outIndex,
	output neuralPkg::activationT outData,
	output logic classValid,
	output logic [$clog2(NEURONS)-1:0] classIndex,
	output neuralPkg::activationT classScore
);

	neuralPkg::featureVectorT features;
	logic vectorValid;
	neuralPkg::nodeWeightsT [NEURONS-1:0] nodeWeights;
	neuralPkg::activationT [NEURONS-1:0] nodeOutputs;

	featureLoader #(
		.NEURONS(NEURONS),
		.FEATURES(FEATURES)
	) u_featureLoader (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.weightWrite(weightWrite),
		.weightNeuron(weightNeuron),
		.weightIndex(weightIndex),
		.weightData(weightData),
		.features(features),
		.vectorValid(vectorValid),
		.nodeWeights(nodeWeights)
	);

	// All neurons see the same vector and run in parallel
	for (genvar n = 0; n < NEURONS; n++)
	begin : gNode
		neuronNode #(
			.FEATURES(FEATURES)
		) u_neuronNode (
			.clk(clk),
			.reset(reset),
			.features(features),
			.weights(nodeWeights[n]),
			.activation(nodeOutputs[n])
		);
	end

	layerCollector #(
		.NEURONS(NEURONS)
	) u_layerCollector (
		.clk(clk),
		.reset(reset),
		.vectorValid(vectorValid),
		.nodeOutputs(nodeOutputs),
		.outValid(outValid),
		.outIndex(outIndex),
		.outData(outData),
		.classValid(classValid),
		.classIndex(classIndex),
		.classScore(classScore)
	);

endmodule

/* sim/clockGen.sv */
`timescale 1ns/10ps

module clockGen #(
	parameter int PERIOD = 8
)
(
	output logic clk
);

	// Free-running clock, low for the first half period
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

endmodule

/* sim/neuralLayer_chk.sv */
`timescale 1ns/10ps

module neuralLayerChk #(
	parameter int NEURONS = 4
)
(
	input logic clk,
	input logic reset,
	input logic outValid,
	input logic [$clog2(NEURONS)-1:0] outIndex,
	input neuralPkg::activationT outData,
	input logic classValid
);

	// Reset leaves both output strobes low
	resetQuiet: assert property (@(posedge clk) reset |=> (!outValid && !classValid))
		else $error("outValid or classValid high in the cycle after reset");

	classAfterStream: assert property (@(posedge clk) disable iff (reset)
		$fell(outValid) |-> classValid)
		else $error("classValid missing one cycle after the output stream");

	classOnlyAfterStream: assert property (@(posedge clk) disable iff (reset)
		classValid |-> $fell(outValid))
		else $error("classValid pulsed without a just ended output stream");

	// The rectifier never lets a negative value out
	dataNotNegative: assert property (@(posedge clk) disable iff (reset) !outData[7])
		else $error("outData is negative");

	indexSteps: assert property (@(posedge clk) disable iff (reset)
		(outValid && $past(outValid)) |-> (outIndex == $past(outIndex) + 1'b1))
		else $error("outIndex did not step by one inside the output stream");

endmodule

/* sim/neuralLayerTb.sv */
`timescale 1ns/10ps

module neuralLayerTb;

	localparam int NEURONS = 4;
	localparam int FEATURES = neuralPkg::FEATURES;
	localparam int INDEX_W = $clog2(NEURONS);
	localparam int WINDEX_W = $clog2(FEATURES + 1);
	localparam int LATENCY = 4; // Last strobe edge to the first outValid

	logic clk;
	logic reset;
	logic sampleValid;
	neuralPkg::activationT sampleData;
	logic weightWrite;
	logic [INDEX_W-1:0] weightNeuron;
	logic [WINDEX_W-1:0] weightIndex;
	neuralPkg::weightT weightData;
	logic outValid;
	logic [INDEX_W-1:0] outIndex;
	neuralPkg::activationT outData;
	logic classValid;
	logic [INDEX_W-1:0] classIndex;
	neuralPkg::activationT classScore;

	string caseLines[$];
	int caseCount = 0;
	int writeCount = 0;
	bit loaded = 1'b0;
	int cycle = 0;
	logic [31:0] rngState;
	int sampleBuf[FEATURES];
	int expected[$]; // Per vector the activations, then class index and score
	int startCycles[$];
	int sentCount = 0;
	int checkedCount = 0;
	int streamPos = 0;
	int currentExp[NEURONS+2];

	clockGen #(
		.PERIOD(8)
	) u_clockGen (
		.clk(clk)
	);

	neuralLayer #(
		.NEURONS(NEURONS),
		.FEATURES(FEATURES)
	) u_neuralLayer (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.weightWrite(weightWrite),
		.weightNeuron(weightNeuron),
		.weightIndex(weightIndex),
		.weightData(weightData),
		.outValid(outValid),
		.outIndex(outIndex),
		.outData(outData),
		.classValid(classValid),
		.classIndex(classIndex),
		.classScore(classScore)
	);

	bind neuralLayer neuralLayerChk #(
		.NEURONS(NEURONS)
	) u_neuralLayerChk (
		.clk(clk),
		.reset(reset),
		.outValid(outValid),
		.outIndex(outIndex),
		.outData(outData),
		.classValid(classValid)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic reportMismatch(input string name, input int want, input int got);
		$display("FAIL at %0t: %s expected %0d, got %0d", $time, name, want, got);
		$display("Result: FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic reportProblem(input string what);
		$display("Error at %0t: %s", $time, what);
		$display("Result: FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic checkValue(input string name, input int want, input int got);
		assert (want == got)
		else reportMismatch(name, want, got);
	endtask

	task automatic loadCases();
		int fd;
		int status;
		string line;
		fd = $fopen("sim/layerCases.txt", "r");
		assert (fd != 0)
		else reportProblem("cannot open sim/layerCases.txt");
		while (!$feof(fd))
		begin
			status = $fgets(line, fd);
			if (status > 0)
			begin
				caseLines.push_back(line);
				if (line[0] == "S")
					caseCount++;
				else if (line[0] == "W")
					writeCount++;
			end
		end
		$fclose(fd);
	endtask

	// Weights may only change once every vector in flight has been checked
	task automatic waitForStreams();
		while (checkedCount != sentCount)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic writeWeight(input int neuron, input int index, input int value);
		weightWrite = 1'b1;
		weightNeuron = INDEX_W'(neuron);
		weightIndex = WINDEX_W'(index);
		weightData = neuralPkg::weightT'(value);
		@(posedge clk);
		#1;
		weightWrite = 1'b0;
	endtask

	task automatic sendVector();
		int gap;
		for (int i = 0; i < FEATURES; i++)
		begin
			rngState = xorshift(rngState);
			gap = int'(rngState[1:0]); // Zero to three idle cycles
			repeat (gap)
			begin
				@(posedge clk);
				#1;
			end
			sampleValid = 1'b1;
			sampleData = neuralPkg::activationT'(sampleBuf[i]);
			if (i == FEATURES - 1)
				startCycles.push_back(cycle + 1 + LATENCY);
			@(posedge clk);
			#1;
			sampleValid = 1'b0;
		end
		sentCount++;
	endtask

	task automatic parseLine(input string line);
		int n;
		int v[NEURONS+2];
		case (line[0])
			"W":
			begin
				n = $sscanf(line, "W %d %d %d", v[0], v[1], v[2]);
				assert (n == 3)
				else reportProblem({"malformed weight line: ", line});
				waitForStreams();
				writeWeight(v[0], v[1], v[2]);
			end
			"S":
			begin
				n = $sscanf(line, "S %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
					sampleBuf[0], sampleBuf[1], sampleBuf[2], sampleBuf[3], sampleBuf[4],
					sampleBuf[5], sampleBuf[6], sampleBuf[7], sampleBuf[8], sampleBuf[9],
					sampleBuf[10], sampleBuf[11], sampleBuf[12], sampleBuf[13], sampleBuf[14]);
				assert (n == FEATURES)
				else reportProblem({"malformed sample line: ", line});
				sendVector();
			end
			"E":
			begin
				n = $sscanf(line, "E %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5]);
				assert (n == NEURONS + 2)
				else reportProblem({"malformed expect line: ", line});
				for (int i = 0; i < NEURONS + 2; i++)
					expected.push_back(v[i]);
			end
			default:
				n = 0; // Comment or blank line
		endcase
	endtask

	task automatic watchOutputs();
		if (outValid)
		begin
			if (streamPos == 0)
			begin
				assert ((startCycles.size() > 0) && (expected.size() >= NEURONS + 2))
				else reportProblem("an output stream started with no vector to expect");
				checkValue("first outValid cycle", startCycles.pop_front(), cycle);
				for (int i = 0; i < NEURONS + 2; i++)
					currentExp[i] = expected.pop_front();
			end
			assert (streamPos < NEURONS)
			else reportProblem("outValid stayed high for more than NEURONS cycles");
			checkValue("outIndex", streamPos, int'(outIndex));
			checkValue("outData", currentExp[streamPos], int'(outData));
			checkValue("classValid", 0, int'(classValid));
			streamPos++;
		end
		else if (streamPos > 0)
		begin
			checkValue("output stream length", NEURONS, streamPos);
			checkValue("classValid", 1, int'(classValid));
			checkValue("classIndex", currentExp[NEURONS], int'(classIndex));
			checkValue("classScore", currentExp[NEURONS+1], int'(classScore));
			streamPos = 0;
			checkedCount++;
		end
		else
			checkValue("classValid", 0, int'(classValid));
	endtask

	// Outputs are sampled mid-cycle where they are settled
	always @(negedge clk)
	begin
		if (!reset)
			watchOutputs();
	end

	initial
	begin
		wait (loaded);
		repeat (caseCount * 100 + writeCount + 50) @(posedge clk);
		reportProblem("the run did not finish before the watchdog expired");
	end

	initial
	begin
		reset = 1'b1;
		sampleValid = 1'b0;
		sampleData = '0;
		weightWrite = 1'b0;
		weightNeuron = '0;
		weightIndex = '0;
		weightData = '0;
		rngState = 32'd57;
		loadCases();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		foreach (caseLines[n])
			parseLine(caseLines[n]);
		waitForStreams();
		if ((sentCount > 0) && (checkedCount == sentCount) && (expected.size() == 0))
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
			reportProblem("the expect lines do not match the vectors that were sent");
	end

endmodule

/* sim/layerCases.txt */
# W neuron index value : one weight write, index 15 is the bias
# S feature0 .. feature14 : one vector, E act0 act1 act2 act3 classIndex classScore
W 0 0 10
W 0 1 -8
W 0 6 100
W 1 2 7
W 1 3 3
W 2 0 -4
W 2 4 12
W 3 1 2
W 3 5 -30
S 20 -11 9 -7 15 -3 0 -1 0 127 -128 64 -64 1 -100
E 5 1 2 1 0 5
S 127 -128 -100 50 -20 -10 127 3 -3 7 -7 0 0 90 -90
E 127 0 0 1 0 127
W 0 15 -128
W 1 15 100
W 2 15 127
W 3 15 -100
S 20 -11 9 -7 15 -3 0 -1 0 127 -128 64 -64 1 -100
E 3 2 4 0 2 4
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E 0 2 2 0 1 2
W 1 15 0
W 2 15 -1
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E 0 0 0 0 0 0
W 3 14 50
S 20 -11 9 -7 15 -3 0 -1 0 127 -128 64 -64 1 100
E 3 1 2 78 3 78
S -20 11 0 0 0 0 0 0 0 0 0 0 0 0 -100
E 0 0 1 0 2 1

/* project.f */
source/neuralPkg.sv
source/featureLoader.sv
source/neuronNode.sv
source/layerCollector.sv
source/neuralLayer.sv
sim/clockGen.sv
sim/neuralLayer_chk.sv
sim/neuralLayerTb.sv

/* build.sh */
#!/usr/bin/env bash
# Builds the neural layer testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module neuralLayerTb \
	--Mdir obj_dir \
	-o neuralLayerSim \
	-f project.f
if [ $? -ne 0 ]; then
	echo "Verilator compilation failed"
	exit 1
fi

output=$(./obj_dir/neuralLayerSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
	exit 0
else
	echo "Pass message not found in the simulation output"
	exit 1
fi
